/* uart_consts.svh */
/*
 * UART echo constants: clock, baud rate, bit timing and FIFO depth
 */

`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// clocking
//////////////////////////////////////////////////////////////////////

// system clock in MHz
`define UART_CLK_FRE_MHZ 50

// line rate, 8N1 frames
`define UART_BAUD_RATE 115200

// clocks per serial bit, integer division so keep the ratio exact
`define UART_CYCLES_PER_BIT ((`UART_CLK_FRE_MHZ * 1000000) / `UART_BAUD_RATE)

//////////////////////////////////////////////////////////////////////
// buffering
//////////////////////////////////////////////////////////////////////

// echo FIFO entries, power of two
`define UART_FIFO_DEPTH 8

`endif

/* uart_pkg.sv */
/*
 * UART echo types shared by the receiver, FIFO and transmitter
 */

package uart_pkg;

	//////////////////////////////////////////////////////////////////////
	// payload
	//////////////////////////////////////////////////////////////////////

	// one data word on the wire
	typedef logic [7:0] uart_byte_t;

	// byte plus valid, travels rx -> fifo -> tx
	// ready runs back upstream as its own wire
	typedef struct packed {
		uart_byte_t data; // payload, lsb sent first
		logic       valid; // held until ready seen
	} rx_frame_t;

	//////////////////////////////////////////////////////////////////////
	// state encodings
	//////////////////////////////////////////////////////////////////////

	// receiver FSM
	typedef enum logic [2:0] {
		RX_IDLE,  // line high, waiting for falling edge
		RX_START, // inside start bit, glitch check at mid
		RX_DATA,  // 8 data bits, lsb first
		RX_STOP,  // stop bit sampled at mid
		RX_HOLD   // byte presented downstream
	} rx_state_t;

	// transmitter FSM
	typedef enum logic [1:0] {
		TX_IDLE,  // line high, ready when cts
		TX_START, // driving start bit
		TX_DATA,  // shifting data out
		TX_STOP   // high for a full bit
	} tx_state_t;

endpackage

/* uart_rx.sv */
/*
 * UART receiver, 8N1: start detect, mid-bit sampling, stop bit check,
 * byte held on a valid/ready link until taken or a new frame starts
 */

`include "uart_consts.svh"

module uart_rx
	import uart_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      rx_pin,      // async serial in
	output rx_frame_t rx_frame,    // received byte + valid
	input  logic      rx_ready,    // downstream accepts
	output logic      frame_error  // one cycle on bad stop bit
);

	localparam int CPB = `UART_CYCLES_PER_BIT;
	localparam int CW  = $clog2(CPB);

	localparam logic [CW-1:0] LAST = CW'(CPB - 1);     // end of a bit period
	localparam logic [CW-1:0] HALF = CW'(CPB / 2 - 1); // middle of a bit period

	rx_state_t  state;
	logic       sync0;    // first sync flop
	logic       sync1;    // second sync flop, safe to use
	logic       sync1_q;  // previous synced value for edge detect
	logic       rx_fall;  // start edge
	logic [CW-1:0] cnt;   // baud counter
	logic [2:0] bit_cnt;  // data bit index
	uart_byte_t rx_bits;  // assembled data bits
	uart_byte_t data_q;   // byte on the link
	logic       valid_q;

	//////////////////////////////////////////////////////////////////////
	// input synchronizer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync0   <= 1'b1; // idle line is high
			sync1   <= 1'b1;
			sync1_q <= 1'b1;
		end
		else
		begin
			sync0   <= rx_pin;
			sync1   <= sync0;
			sync1_q <= sync1;
		end
	end

	assign rx_fall = sync1_q & ~sync1; // high -> low on synced line

	//////////////////////////////////////////////////////////////////////
	// frame FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state       <= RX_IDLE;
			cnt         <= '0;
			bit_cnt     <= '0;
			valid_q     <= 1'b0;
			frame_error <= 1'b0;
		end
		else
		begin
			frame_error <= 1'b0;      // strobe, cleared every cycle
			cnt         <= cnt + 1'b1;
			case (state)
				RX_IDLE:
				begin
					cnt <= '0;
					if (rx_fall)
						state <= RX_START;
				end
				RX_START:
				begin
					if (cnt == HALF && sync1)
					begin
						// line back high at mid start, glitch
						state <= RX_IDLE;
						cnt   <= '0;
					end
					else if (cnt == LAST)
					begin
						state   <= RX_DATA;
						cnt     <= '0;
						bit_cnt <= '0;
					end
				end
				RX_DATA:
				begin
					if (cnt == LAST)
					begin
						cnt     <= '0;
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP; // last data bit done
					end
				end
				RX_STOP:
				begin
					if (cnt == HALF)
					begin
						cnt <= '0;
						if (sync1)
						begin
							state   <= RX_HOLD;
							valid_q <= 1'b1; // good frame, offer byte
						end
						else
						begin
							state       <= RX_IDLE;
							frame_error <= 1'b1; // byte discarded
						end
					end
				end
				RX_HOLD:
				begin
					cnt <= '0;
					if (rx_fall)
					begin
						// serial line can't wait, next frame wins
						state   <= RX_START;
						valid_q <= 1'b0;
					end
					else if (rx_ready)
					begin
						state   <= RX_IDLE; // transfer this cycle
						valid_q <= 1'b0;
					end
				end
				default:
				begin
					state   <= RX_IDLE;
					cnt     <= '0;
					valid_q <= 1'b0;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// payload registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && cnt == HALF)
			rx_bits[bit_cnt] <= sync1; // mid-bit sample
		if (state == RX_STOP && cnt == HALF && sync1)
			data_q <= rx_bits;         // latch with valid
	end

	assign rx_frame = '{data: data_q, valid: valid_q};

endmodule

/* uart_fifo.sv */
/*
 * byte FIFO between receiver and transmitter, drops and flags bytes
 * that arrive while full
 */

`include "uart_consts.svh"

module uart_fifo
	import uart_pkg::*;
#(
	parameter int DEPTH = `UART_FIFO_DEPTH // power of two
)
(
	input  logic      clk,
	input  logic      rst_n,
	input  rx_frame_t in_frame,  // from receiver
	output logic      in_ready,
	output rx_frame_t out_frame, // head of queue
	input  logic      out_ready,
	output logic      overflow   // one cycle per dropped byte
);

	localparam int AW = $clog2(DEPTH);

	uart_byte_t    mem [DEPTH];
	logic [AW-1:0] wr_ptr;  // wraps, depth is 2^AW
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;   // 0..DEPTH
	logic          full;
	logic          empty;
	logic          push;
	logic          pop;

	assign full  = (count == (AW+1)'(DEPTH));
	assign empty = (count == '0);

	assign pop  = out_frame.valid & out_ready;
	assign push = in_frame.valid & (~full | pop); // slot freed same cycle

	// ready when not full, also when full so an incoming byte is released
	assign in_ready = ~full | in_frame.valid;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // none, or both
			endcase
			overflow <= in_frame.valid & full & ~pop; // byte dropped
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= in_frame.data;
	end

	assign out_frame = '{data: mem[rd_ptr], valid: ~empty};

endmodule

/* uart_tx.sv */
/*
 * UART transmitter, 8N1, takes a byte over valid/ready only while cts
 * is high; a started frame always finishes
 */

`include "uart_consts.svh"

module uart_tx
	import uart_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  rx_frame_t tx_frame, // byte to send
	output logic      tx_ready, // idle and cts
	input  logic      cts,      // clear to send
	output logic      tx_pin    // serial out, high when idle
);

	localparam int CPB = `UART_CYCLES_PER_BIT;
	localparam int CW  = $clog2(CPB);

	localparam logic [CW-1:0] LAST = CW'(CPB - 1);

	tx_state_t     state;
	logic [CW-1:0] cnt;      // clocks into current bit
	logic [2:0]    bit_cnt;  // data bit on the line
	uart_byte_t    shift;    // remaining data bits, lsb next
	logic          load;     // transfer from FIFO
	logic          bit_end;  // last clock of a bit

	assign tx_ready = (state == TX_IDLE) & cts;
	assign load     = tx_frame.valid & tx_ready;
	assign bit_end  = (cnt == LAST);

	//////////////////////////////////////////////////////////////////////
	// line FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= TX_IDLE;
			cnt     <= '0;
			bit_cnt <= '0;
			tx_pin  <= 1'b1; // line idles high
		end
		else
		begin
			cnt <= bit_end ? '0 : cnt + 1'b1;
			case (state)
				TX_IDLE:
				begin
					cnt    <= '0;
					tx_pin <= 1'b1;
					if (load)
					begin
						state  <= TX_START;
						tx_pin <= 1'b0; // start bit from next clock
					end
				end
				TX_START:
				begin
					if (bit_end)
					begin
						state   <= TX_DATA;
						bit_cnt <= '0;
						tx_pin  <= shift[0]; // data bit 0
					end
				end
				TX_DATA:
				begin
					if (bit_end)
					begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
						begin
							state  <= TX_STOP;
							tx_pin <= 1'b1; // stop bit
						end
						else
							tx_pin <= shift[0];
					end
				end
				TX_STOP:
				begin
					if (bit_end)
						state <= TX_IDLE; // ready next cycle
				end
				default:
				begin
					state  <= TX_IDLE;
					tx_pin <= 1'b1;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// data shifter, payload only
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (load)
			shift <= tx_frame.data;
		else if (bit_end && (state == TX_START || state == TX_DATA))
			shift <= {1'b0, shift[7:1]}; // next bit to position 0
	end

endmodule

/* uart_echo_top.sv */
/*
 * UART echo: receiver -> byte FIFO -> transmitter with cts flow control
 */

module uart_echo_top
	import uart_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic rx_pin,      // serial in
	input  logic cts,         // far end can take data
	output logic tx_pin,      // echoed serial out
	output logic frame_error, // bad stop bit strobe
	output logic overflow     // dropped byte strobe
);

	rx_frame_t rx_frame;   // receiver -> fifo
	logic      rx_ready;
	rx_frame_t tx_frame;   // fifo -> transmitter
	logic      tx_ready;

	uart_rx i_rx (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_pin      (rx_pin),
		.rx_frame    (rx_frame),
		.rx_ready    (rx_ready),
		.frame_error (frame_error)
	);

	// default depth from the constants header
	uart_fifo i_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_frame  (rx_frame),
		.in_ready  (rx_ready),
		.out_frame (tx_frame),
		.out_ready (tx_ready),
		.overflow  (overflow)
	);

	uart_tx i_tx (
		.clk      (clk),
		.rst_n    (rst_n),
		.tx_frame (tx_frame),
		.tx_ready (tx_ready),
		.cts      (cts),
		.tx_pin   (tx_pin)
	);

endmodule

/* tb_clock_gen.sv */
/*
 * testbench clock and reset: 10 ns clock, reset held for 3 cycles
 */

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 100 MHz
	end

	initial
	begin
		rst_n = 1'b1;
		#1 rst_n = 1'b0;          // real falling edge for the async resets
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;             // release away from the active edge
	end

endmodule

/* uart_echo_assertions.sv */
/*
 * UART echo protocol checks: reset levels, tx start and stop bit
 * timing, single-cycle error strobes
 */

`include "uart_consts.svh"

module uart_echo_assertions (
	input logic clk,
	input logic rst_n,
	input logic tx_pin,
	input logic frame_error,
	input logic overflow
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CPB   = `UART_CYCLES_PER_BIT;
	localparam int FRAME = 10 * CPB; // start, 8 data, stop

	logic tx_q;     // tx_pin one cycle back
	logic busy;     // inside an outgoing frame
	int   pos;      // cycle index within that frame
	int   fail_cnt; // assertion failures so far

	// follows tx_pin from its start edge through the stop bit
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			tx_q <= 1'b1;
			busy <= 1'b0;
			pos  <= 0;
		end
		else
		begin
			tx_q <= tx_pin;
			if (!busy && tx_q && !tx_pin)
			begin
				busy <= 1'b1;
				pos  <= 1; // cycle 0 was the falling edge
			end
			else if (busy)
			begin
				if (pos == FRAME - 1)
					busy <= 1'b0;
				pos <= pos + 1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// properties
	//////////////////////////////////////////////////////////////////////

	reset_quiet: assert property (@(posedge clk)
		!rst_n |-> tx_pin && !frame_error && !overflow)
	else
	begin
		$error("outputs not idle while reset is held");
		fail_cnt++;
	end

	reset_exit: assert property (@(posedge clk)
		$rose(rst_n) |-> tx_pin && !frame_error && !overflow)
	else
	begin
		$error("outputs not idle right after reset");
		fail_cnt++;
	end

	// start bit low for its whole period
	start_bit: assert property (@(posedge clk) disable iff (!rst_n)
		(busy && pos < CPB) |-> !tx_pin)
	else
	begin
		$error("tx start bit shorter than one bit period");
		fail_cnt++;
	end

	// line only moves on bit boundaries, so no bit runs long or short
	bit_edges: assert property (@(posedge clk) disable iff (!rst_n)
		(busy && (pos % CPB) != 0) |-> $stable(tx_pin))
	else
	begin
		$error("tx line changed inside a bit period");
		fail_cnt++;
	end

	stop_bit: assert property (@(posedge clk) disable iff (!rst_n)
		(busy && pos >= 9 * CPB) |-> tx_pin)
	else
	begin
		$error("tx stop bit not high for a full bit period");
		fail_cnt++;
	end

	fe_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		frame_error |=> !frame_error)
	else
	begin
		$error("frame_error high for more than one cycle");
		fail_cnt++;
	end

	ovf_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		overflow |=> !overflow)
	else
	begin
		$error("overflow high for more than one cycle");
		fail_cnt++;
	end

endmodule

/* uart_echo_tb.sv */
/*
 * UART echo testbench: serial sender, tx_pin decoder, directed tests
 * for reset, echo, burst, framing error and cts flow control
 */

`include "uart_consts.svh"

module uart_echo_tb
	import uart_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CPB    = `UART_CYCLES_PER_BIT;
	localparam int DEPTH  = `UART_FIFO_DEPTH;
	localparam int BURST  = 20;
	localparam int FRAMES = 1 + BURST + 2 + DEPTH + 2; // frames sent, all tests
	localparam int LIMIT  = (2 * FRAMES * 12 + 100) * CPB; // in and out, plus slack

	logic        clk;
	logic        rst_n;
	logic        rx_pin;
	logic        cts;
	logic        tx_pin;
	logic        frame_error;
	logic        overflow;
	logic [15:0] lfsr;         // stimulus generator state
	uart_byte_t  exp_q [$];    // bytes the echo has to return
	uart_byte_t  got_q [$];    // bytes decoded from tx_pin
	int          got_base;     // first got_q entry of the running test
	int          fe_pulses;    // frame_error strobes
	int          ov_pulses;    // overflow strobes
	int          tx_low;       // cycles with tx_pin low
	int          bad_stops;    // echoes with a low stop bit
	int          errors;
	int          err_base;
	int          fe_base;
	int          ov_base;
	int          low_base;
	int          stop_base;
	int          chk_base;     // assertion failures before the test
	int          tests_run;
	int          tests_failed;

	tb_clock_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

	uart_echo_top i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_pin      (rx_pin),
		.cts         (cts),
		.tx_pin      (tx_pin),
		.frame_error (frame_error),
		.overflow    (overflow)
	);

	bind uart_echo_top uart_echo_assertions i_checks (
		.clk         (clk),
		.rst_n       (rst_n),
		.tx_pin      (tx_pin),
		.frame_error (frame_error),
		.overflow    (overflow)
	);

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic random_byte(output uart_byte_t b);
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsr_next(lfsr); // one step per bit taken
			b    = {b[6:0], lfsr[0]};
		end
	endtask

	// one 8N1 frame, lsb first, called on a falling edge
	task automatic send_frame(input uart_byte_t b, input logic stop);
		logic [9:0] bits;
		bits = {stop, b, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			rx_pin = bits[i];
			repeat (CPB) @(negedge clk);
		end
		rx_pin = 1'b1; // back to idle
	endtask

	//////////////////////////////////////////////////////////////////////
	// monitors
	//////////////////////////////////////////////////////////////////////

	// tx_pin decoder, samples at mid-bit
	initial
	begin
		uart_byte_t b;
		forever
		begin
			@(negedge tx_pin);
			repeat (CPB / 2) @(negedge clk); // middle of start
			for (int i = 0; i < 8; i++)
			begin
				repeat (CPB) @(negedge clk);
				b[i] = tx_pin;
			end
			repeat (CPB) @(negedge clk);
			if (!tx_pin)
				bad_stops++;
			got_q.push_back(b);
		end
	end

	always @(negedge clk)
	begin
		if (frame_error)
			fe_pulses++;
		if (overflow)
			ov_pulses++;
		if (rst_n && !tx_pin)
			tx_low++;
	end

	//////////////////////////////////////////////////////////////////////
	// checking and reporting
	//////////////////////////////////////////////////////////////////////

	// waits for the expected echoes, then one more frame time for strays
	task automatic check_echoes();
		int n;
		n = exp_q.size();
		while (got_q.size() - got_base < n)
			@(negedge clk);
		repeat (12 * CPB) @(negedge clk);
		if (got_q.size() - got_base != n)
		begin
			$display("MISMATCH at %0t: %0d echoes, expected %0d", $time,
				got_q.size() - got_base, n);
			errors++;
		end
		for (int i = 0; i < n; i++)
			if (got_q[got_base + i] !== exp_q[i])
			begin
				$display("MISMATCH at %0t: echo %0d is %h, expected %h", $time, i,
					got_q[got_base + i], exp_q[i]);
				errors++;
			end
		got_base = got_q.size();
		exp_q.delete();
	endtask

	task automatic expect_pulses(input string what, input int got, input int want);
		if (got != want)
		begin
			$display("MISMATCH at %0t: %s pulses %0d, expected %0d", $time, what, got, want);
			errors++;
		end
	endtask

	task automatic start_test();
		err_base  = errors;
		fe_base   = fe_pulses;
		ov_base   = ov_pulses;
		low_base  = tx_low;
		stop_base = bad_stops;
		chk_base  = i_dut.i_checks.fail_cnt;
	endtask

	task automatic end_test(input string name, input int fe_want, input int ov_want);
		expect_pulses("frame_error", fe_pulses - fe_base, fe_want);
		expect_pulses("overflow", ov_pulses - ov_base, ov_want);
		if (bad_stops != stop_base)
		begin
			$display("an echoed frame had a low stop bit on tx_pin");
			errors++;
		end
		if (i_dut.i_checks.fail_cnt != chk_base)
		begin
			$display("a protocol assertion failed during the test");
			errors++;
		end
		tests_run++;
		if (errors == err_base)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - err_base);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		uart_byte_t b;
		rx_pin = 1'b1;
		cts    = 1'b1;
		lfsr   = 16'd75;
		@(negedge rst_n);
		@(posedge rst_n);
		@(negedge clk);

		start_test(); // idle line after reset
		repeat (4 * CPB) @(negedge clk);
		if (tx_low != low_base || got_q.size() != 0)
		begin
			$display("tx_pin left idle after reset with no traffic");
			errors++;
		end
		end_test("reset", 0, 0);

		start_test();
		random_byte(b);
		exp_q.push_back(b);
		send_frame(b, 1'b1);
		check_echoes();
		end_test("single_echo", 0, 0);

		start_test(); // back to back frames
		repeat (BURST)
		begin
			random_byte(b);
			exp_q.push_back(b);
			send_frame(b, 1'b1);
		end
		check_echoes();
		end_test("burst", 0, 0);

		start_test();
		random_byte(b);
		send_frame(b, 1'b0);          // low stop bit, dropped
		repeat (CPB) @(negedge clk);  // idle high so the next start edge shows
		random_byte(b);
		exp_q.push_back(b);
		send_frame(b, 1'b1);
		check_echoes();
		end_test("framing_error", 1, 0);

		start_test(); // cts low fills the FIFO, last two are dropped
		cts = 1'b0;
		for (int i = 0; i < DEPTH + 2; i++)
		begin
			random_byte(b);
			if (i < DEPTH)
				exp_q.push_back(b);
			send_frame(b, 1'b1);
		end
		repeat (CPB) @(negedge clk);
		if (tx_low != low_base)
		begin
			$display("tx_pin sent data while cts was low");
			errors++;
		end
		cts = 1'b1;
		check_echoes();
		end_test("flow_control", 0, 2);

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && i_dut.i_checks.fail_cnt == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// watchdog, frames in both directions at 12 bit periods each
	initial
	begin
		repeat (LIMIT) @(posedge clk);
		$display("watchdog expired after %0d cycles, the tests did not finish", LIMIT);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* all.f */
+incdir+.
uart_pkg.sv
uart_rx.sv
uart_fifo.sv
uart_tx.sv
uart_echo_top.sv
tb_clock_gen.sv
uart_echo_assertions.sv
uart_echo_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = uart_echo_tb
FILELIST  = all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
